// ==== hdl/adc_pkg.sv ====
package adc_pkg;

    // ------------------------------------------------------------
    // ADC side geometry
    // ------------------------------------------------------------

    // two bits of every sample per lane, even then odd
    localparam int N_LANES  = 7;   // data lanes per channel
    localparam int SAMPLE_W = 14;  // bits per channel sample

    // per-lane delay setting, whole clk cycles
    localparam int DELAY_W  = 2;   // 0 .. 3 cycles

    // one rebuilt channel sample, lane i gives bits 2i and 2i+1
    typedef logic [SAMPLE_W-1:0] sample_t;

    // one channel's lane vector, bit i is lane i
    typedef logic [N_LANES-1:0] lane_t;

endpackage

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

    // ------------------------------------------------------------
    // register bus widths
    // ------------------------------------------------------------

    localparam int ADDR_W = 8;   // request address
    localparam int DATA_W = 32;  // write and read data

    // ------------------------------------------------------------
    // sfr map, region bit clear
    // ------------------------------------------------------------

    localparam logic [1:0] REG_PAIR0      = 2'd0;  // ping-pong slot 0
    localparam logic [1:0] REG_PAIR1      = 2'd1;  // ping-pong slot 1
    localparam logic [1:0] REG_FRAME_RATE = 2'd2;  // frames per gate window
    // index 3 is not mapped and reads zero

    // sfr view of an address word
    typedef struct packed {
        logic              region;  // 0 here
        logic [ADDR_W-4:0] unused;
        logic [1:0]        index;   // register index
    } sfr_addr_t;

    // delay view of an address word
    typedef struct packed {
        logic              region;  // 1 here
        logic [ADDR_W-6:0] unused;
        logic              chan;    // 0 = channel A, 1 = channel B
        logic [2:0]        lane;    // lane index, 7 is not a lane
    } delay_addr_t;

    // one address word, two decodes
    // region bit is the msb in both views, so either can test it
    typedef union packed {
        sfr_addr_t   sfr;
        delay_addr_t dly;
    } reg_addr_u;

endpackage

// ==== hdl/adc_capture_if.sv ====
`timescale 1ns/1ps

// ------------------------------------------------------------
// delay settings, decode -> capture
// ------------------------------------------------------------
interface lane_cfg_if import adc_pkg::*; ();

    // static values, no handshake
    logic [N_LANES-1:0][DELAY_W-1:0] delay_a;  // one per channel A lane
    logic [N_LANES-1:0][DELAY_W-1:0] delay_b;  // one per channel B lane

    modport source (
        output delay_a,
        output delay_b
    );

    modport sink (
        input delay_a,
        input delay_b
    );

endinterface

// ------------------------------------------------------------
// captured samples, capture -> monitor
// ------------------------------------------------------------
interface sample_if import adc_pkg::*; ();

    logic    valid;       // one-cycle pulse per sample pair
    sample_t sample_a;    // held until next valid
    sample_t sample_b;
    logic    frame_seen;  // one pulse per frame-lane high cycle

    modport source (
        output valid,
        output sample_a,
        output sample_b,
        output frame_seen
    );

    // no ready, the monitor takes every pair
    modport sink (
        input valid,
        input sample_a,
        input sample_b,
        input frame_seen
    );

endinterface

// ==== hdl/reg_decode.sv ====
`timescale 1ns/1ps

module reg_decode import adc_pkg::*, bus_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  logic               req_write,
    input  reg_addr_u          req_addr,
    input  logic [DATA_W-1:0]  req_wdata,
    output logic               rd_pulse,     // read request this cycle
    output logic [1:0]         rd_index,     // sfr index of the read
    output logic               delay_sel,    // read targets the delay region
    output logic [DELAY_W-1:0] delay_rdata,  // addressed delay setting
    output logic               resp_valid,
    lane_cfg_if.source         cfg
);

    // [0] = channel A, [1] = channel B
    logic [1:0][N_LANES-1:0][DELAY_W-1:0] delay_q;

    logic lane_ok;   // lane index names a real lane
    logic wr_delay;  // write into the delay region

    // ------------------------------------------------------------
    // request decode
    // ------------------------------------------------------------

    assign lane_ok  = (req_addr.dly.lane < 3'(N_LANES));
    assign wr_delay = req_valid && req_write && req_addr.dly.region && lane_ok;

    // read side goes straight to the monitor, which registers the word
    // so data lines up with resp_valid one cycle after the request
    assign rd_pulse  = req_valid && !req_write;
    assign rd_index  = req_addr.sfr.index;
    assign delay_sel = req_addr.sfr.region;  // same bit as dly.region

    always_comb begin
        delay_rdata = '0;  // lane 7 reads back zero
        if (lane_ok) begin
            delay_rdata = delay_q[req_addr.dly.chan][req_addr.dly.lane];
        end
    end

    // ------------------------------------------------------------
    // delay registers
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            delay_q <= '0;  // all lanes undelayed
        end else if (wr_delay) begin
            // only the low bits of the write word matter
            delay_q[req_addr.dly.chan][req_addr.dly.lane] <= req_wdata[DELAY_W-1:0];
        end
    end

    assign cfg.delay_a = delay_q[0];  // capture sees it the cycle after the write
    assign cfg.delay_b = delay_q[1];

    // ------------------------------------------------------------
    // response strobe
    // ------------------------------------------------------------

    // every request answered, reads and writes alike
    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid;
        end
    end

endmodule

// ==== hdl/lane_capture.sv ====
`timescale 1ns/1ps

module lane_capture import adc_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  lane_t    lane_a,
    input  lane_t    lane_b,
    input  logic     frame,  // high in the even-bit cycle
    lane_cfg_if.sink cfg,
    sample_if.source smp
);

    // one history stage per nonzero delay
    localparam int HIST_D = 2**DELAY_W - 1;

    // channels side by side, [0] = A, [1] = B
    lane_t                           lanes  [2];
    logic [N_LANES-1:0][DELAY_W-1:0] dly    [2];
    logic [N_LANES-1:0][HIST_D-1:0]  hist   [2];  // bit 0 is one cycle old
    lane_t                           tapped [2];  // lane bits after delay
    lane_t                           even_q [2];  // even bits of the pending sample
    sample_t                         joined [2];  // even and odd bits merged
    logic                            odd_cycle;   // cycle after frame

    assign lanes[0] = lane_a;
    assign lanes[1] = lane_b;
    assign dly[0]   = cfg.delay_a;
    assign dly[1]   = cfg.delay_b;

    // ------------------------------------------------------------
    // per-lane delay lines
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        for (int ch = 0; ch < 2; ch++) begin
            for (int i = 0; i < N_LANES; i++) begin
                hist[ch][i] <= {hist[ch][i][HIST_D-2:0], lanes[ch][i]};
            end
        end
    end

    // delay d picks the bit from d cycles back, d = 0 is the live lane
    always_comb begin
        logic [HIST_D:0] taps;
        for (int ch = 0; ch < 2; ch++) begin
            for (int i = 0; i < N_LANES; i++) begin
                taps = {hist[ch][i], lanes[ch][i]};
                tapped[ch][i] = taps[dly[ch][i]];
            end
        end
    end

    // ------------------------------------------------------------
    // DDR deinterleave
    // ------------------------------------------------------------

    // even bits held from the frame cycle
    always_ff @(posedge clk) begin
        if (frame) begin
            even_q[0] <= tapped[0];
            even_q[1] <= tapped[1];
        end
    end

    // lane i -> bits 2i (even) and 2i+1 (odd, live this cycle)
    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            for (int i = 0; i < N_LANES; i++) begin
                joined[ch][2*i]   = even_q[ch][i];
                joined[ch][2*i+1] = tapped[ch][i];
            end
        end
    end

    // ------------------------------------------------------------
    // sample output
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            odd_cycle      <= 1'b0;
            smp.valid      <= 1'b0;
            smp.frame_seen <= 1'b0;
        end else begin
            odd_cycle      <= frame;
            smp.valid      <= odd_cycle;  // one cycle after the odd bits
            smp.frame_seen <= frame;      // rate counter input
        end
    end

    // output words hold between pulses, so the next pair
    // assembles in even_q while this one is still visible
    always_ff @(posedge clk) begin
        if (reset) begin
            smp.sample_a <= '0;
            smp.sample_b <= '0;
        end else if (odd_cycle) begin
            smp.sample_a <= joined[0];
            smp.sample_b <= joined[1];
        end
    end

endmodule

// ==== hdl/capture_monitor.sv ====
`timescale 1ns/1ps

module capture_monitor import adc_pkg::*, bus_pkg::*; #(
    parameter int GATE_CYCLES = 256  // power of two, 16 .. 4096
) (
    input  logic               clk,
    input  logic               reset,
    sample_if.sink             smp,
    input  logic               rd_pulse,
    input  logic [1:0]         rd_index,
    input  logic               delay_sel,
    input  logic [DELAY_W-1:0] delay_rdata,
    output logic [DATA_W-1:0]  resp_rdata
);

    localparam int GATE_W = $clog2(GATE_CYCLES);
    localparam int CNT_W  = GATE_W + 1;       // up to one frame per cycle
    localparam int HALF_W = DATA_W / 2;       // channel B starts here

    logic [1:0][2*SAMPLE_W-1:0] slot;         // {sample_b, sample_a} per slot
    logic                       ptr;          // next slot to write
    logic [GATE_W-1:0]          gate_cnt;
    logic [CNT_W-1:0]           frame_cnt;    // frames in the running window
    logic [CNT_W-1:0]           rate_q;       // frames in the last full window
    logic                       window_end;
    logic [DATA_W-1:0]          rd_word;

    // ------------------------------------------------------------
    // ping-pong sample slots
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            slot <= '0;
            ptr  <= 1'b0;
        end else if (smp.valid) begin
            slot[ptr] <= {smp.sample_b, smp.sample_a};
            ptr       <= ~ptr;  // alternate slots
        end
    end

    // ------------------------------------------------------------
    // frame-rate counter
    // ------------------------------------------------------------

    assign window_end = (gate_cnt == GATE_W'(GATE_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            gate_cnt  <= '0;
            frame_cnt <= '0;
            rate_q    <= '0;  // reads zero until the first window closes
        end else begin
            gate_cnt <= gate_cnt + 1'b1;  // wraps at GATE_CYCLES
            if (window_end) begin
                // last cycle of the window still counts
                rate_q    <= frame_cnt + CNT_W'(smp.frame_seen);
                frame_cnt <= '0;
            end else begin
                frame_cnt <= frame_cnt + CNT_W'(smp.frame_seen);
            end
        end
    end

    // ------------------------------------------------------------
    // read data
    // ------------------------------------------------------------

    always_comb begin
        rd_word = '0;
        if (delay_sel) begin
            rd_word[DELAY_W-1:0] = delay_rdata;  // zero-extended
        end else begin
            case (rd_index)
                REG_PAIR0, REG_PAIR1: begin
                    // A in the low half, B in the high half
                    rd_word[SAMPLE_W-1:0]        = slot[rd_index[0]][SAMPLE_W-1:0];
                    rd_word[HALF_W +: SAMPLE_W]  = slot[rd_index[0]][SAMPLE_W +: SAMPLE_W];
                end
                REG_FRAME_RATE: rd_word[CNT_W-1:0] = rate_q;
                default:        rd_word = '0;  // index 3
            endcase
        end
    end

    // word lands with resp_valid, one cycle after the request
    always_ff @(posedge clk) begin
        if (reset) begin
            resp_rdata <= '0;
        end else if (rd_pulse) begin
            resp_rdata <= rd_word;
        end
    end

endmodule

// ==== hdl/adc_capture_top.sv ====
`timescale 1ns/1ps

module adc_capture_top import adc_pkg::*, bus_pkg::*; #(
    parameter int GATE_CYCLES = 256  // rate gate window, clk cycles
) (
    input  logic              clk,
    input  logic              reset,
    // ADC lanes, single-ended and aligned to clk
    input  lane_t             lane_a,
    input  lane_t             lane_b,
    input  logic              frame,
    // rebuilt samples
    output logic              sample_valid,
    output sample_t           sample_a,
    output sample_t           sample_b,
    // register bus
    input  logic              req_valid,
    input  logic              req_write,
    input  logic [ADDR_W-1:0] req_addr,
    input  logic [DATA_W-1:0] req_wdata,
    output logic              resp_valid,
    output logic [DATA_W-1:0] resp_rdata
);

    lane_cfg_if cfg_if ();
    sample_if   smp_if ();

    logic               rd_pulse;
    logic [1:0]         rd_index;
    logic               delay_sel;
    logic [DELAY_W-1:0] delay_rdata;

    // ------------------------------------------------------------
    // decode, capture, monitor
    // ------------------------------------------------------------

    reg_decode decode_i (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_addr    (req_addr),    // seen as reg_addr_u inside
        .req_wdata   (req_wdata),
        .rd_pulse    (rd_pulse),
        .rd_index    (rd_index),
        .delay_sel   (delay_sel),
        .delay_rdata (delay_rdata),
        .resp_valid  (resp_valid),
        .cfg         (cfg_if.source)
    );

    lane_capture capture_i (
        .clk    (clk),
        .reset  (reset),
        .lane_a (lane_a),
        .lane_b (lane_b),
        .frame  (frame),
        .cfg    (cfg_if.sink),
        .smp    (smp_if.source)
    );

    capture_monitor #(
        .GATE_CYCLES (GATE_CYCLES)
    ) monitor_i (
        .clk         (clk),
        .reset       (reset),
        .smp         (smp_if.sink),
        .rd_pulse    (rd_pulse),
        .rd_index    (rd_index),
        .delay_sel   (delay_sel),
        .delay_rdata (delay_rdata),
        .resp_rdata  (resp_rdata)
    );

    // sample outputs straight off the capture stage
    assign sample_valid = smp_if.valid;
    assign sample_a     = smp_if.sample_a;
    assign sample_b     = smp_if.sample_b;

endmodule

// ==== verification/adc_capture_tb.sv ====
`timescale 1ns/1ps

module adc_capture_tb import adc_pkg::*, bus_pkg::*; ();

    localparam int GATE = 64;  // rate window for this run

    // DUT inputs start at known values
    logic              clk       = 1'b0;
    logic              reset     = 1'b1;
    lane_t             lane_a    = '0;
    lane_t             lane_b    = '0;
    logic              frame     = 1'b0;
    logic              req_valid = 1'b0;
    logic              req_write = 1'b0;
    logic [ADDR_W-1:0] req_addr  = '0;
    logic [DATA_W-1:0] req_wdata = '0;
    logic              sample_valid;
    sample_t           sample_a;
    sample_t           sample_b;
    logic              resp_valid;
    logic [DATA_W-1:0] resp_rdata;

    int seed = 32'h4615b9bf;

    // ------------------------------------------------------------
    // reference model state
    // ------------------------------------------------------------
    logic [2*N_LANES-1:0] past [8] = '{default: '0};  // {lane_b, lane_a} by cycle number
    int                   dly_m [2][N_LANES] = '{default: 0};
    int                   cyc      = 0;
    int                   even_cyc = 0;
    logic                 in_odd   = 1'b0;   // cycle after a frame cycle
    sample_t              word [2] = '{default: '0};
    logic [DATA_W-1:0]    slot_m [2] = '{default: '0};
    logic                 ptr_m = 1'b0;
    logic                 exp_valid = 1'b0;
    sample_t              exp_a = '0;
    sample_t              exp_b = '0;
    logic                 exp_resp = 1'b0;
    logic                 rd_check = 1'b0;      // last request was a read
    logic [DATA_W-1:0]    exp_rdata = '0;
    logic [DATA_W-1:0]    rd_expect = '0;       // word expected for the read in flight

    adc_capture_top #(.GATE_CYCLES(GATE)) adc_capture_top_i (
        .clk(clk), .reset(reset), .lane_a(lane_a), .lane_b(lane_b), .frame(frame),
        .sample_valid(sample_valid), .sample_a(sample_a), .sample_b(sample_b),
        .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
        .req_wdata(req_wdata), .resp_valid(resp_valid), .resp_rdata(resp_rdata)
    );

    initial begin
        forever begin
            #50 clk = ~clk;  // 100 ns period
        end
    end

    // lane i of a sample, d cycles back, taken from the per-cycle record
    always @(posedge clk) begin
        cyc = cyc + 1;
        past[3'(cyc)] = {lane_b, lane_a};
        if (in_odd) begin
            for (int ch = 0; ch < 2; ch++) begin
                for (int i = 0; i < N_LANES; i++) begin
                    word[ch][2*i]   = past[3'(even_cyc - dly_m[ch][i])][ch*N_LANES+i];
                    word[ch][2*i+1] = past[3'(cyc - dly_m[ch][i])][ch*N_LANES+i];
                end
            end
            exp_a <= word[0];
            exp_b <= word[1];
            slot_m[ptr_m] = {2'b00, word[1], 2'b00, word[0]};  // B high, A low
            ptr_m = ~ptr_m;
        end
        exp_valid <= in_odd;  // pulse one cycle after the odd bits
        in_odd = frame;
        if (frame) even_cyc = cyc;
        exp_resp  <= req_valid;
        rd_check  <= req_valid && !req_write;
        exp_rdata <= rd_expect;
    end

    // ------------------------------------------------------------
    // checks, sampled mid-cycle
    // ------------------------------------------------------------
    valid_ok: assert property (@(negedge clk) disable iff (reset) sample_valid == exp_valid)
        else mismatch("sample_valid", 32'(sample_valid), 32'(exp_valid));
    chan_a_ok: assert property (@(negedge clk) disable iff (reset) sample_a == exp_a)
        else mismatch("sample_a", 32'(sample_a), 32'(exp_a));
    chan_b_ok: assert property (@(negedge clk) disable iff (reset) sample_b == exp_b)
        else mismatch("sample_b", 32'(sample_b), 32'(exp_b));
    resp_ok: assert property (@(negedge clk) disable iff (reset) resp_valid == exp_resp)
        else mismatch("resp_valid", 32'(resp_valid), 32'(exp_resp));
    rdata_ok: assert property (@(negedge clk) disable iff (reset)
        !rd_check || resp_rdata == exp_rdata)
        else mismatch("resp_rdata", resp_rdata, exp_rdata);

    task automatic stop_failed();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic mismatch(input string name, input logic [31:0] got,
                            input logic [31:0] want);
        $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, want);
        stop_failed();
    endtask

    function automatic lane_t pick_bits(input sample_t s, input int odd);
        lane_t v;
        for (int i = 0; i < N_LANES; i++) v[i] = s[2*i+odd];
        return v;
    endfunction

    function automatic logic [ADDR_W-1:0] sfr_addr(input logic [1:0] idx);
        return {1'b0, 5'd0, idx};
    endfunction

    function automatic logic [ADDR_W-1:0] delay_addr(input logic ch, input int lane);
        return {1'b1, 3'd0, ch, 3'(lane)};
    endfunction

    // ------------------------------------------------------------
    // stimulus tasks
    // ------------------------------------------------------------
    task automatic send_samples(input int n);
        sample_t a;
        sample_t b;
        for (int k = 0; k < n; k++) begin
            a = SAMPLE_W'($random(seed));
            b = SAMPLE_W'($random(seed));
            @(posedge clk);
            frame  <= 1'b1;  // even-bit cycle
            lane_a <= pick_bits(a, 0);
            lane_b <= pick_bits(b, 0);
            @(posedge clk);
            frame  <= 1'b0;
            lane_a <= pick_bits(a, 1);
            lane_b <= pick_bits(b, 1);
        end
        @(posedge clk);
        lane_a <= '0;
        lane_b <= '0;
    endtask

    task automatic write_delay(input logic ch, input int lane, input int value);
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= 1'b1;
        req_addr  <= delay_addr(ch, lane);
        req_wdata <= DATA_W'(value);
        if (lane < N_LANES) dly_m[ch][lane] = value;  // lane 7 is no lane
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] want);
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= 1'b0;
        req_addr  <= addr;
        rd_expect <= want;
    endtask

    task automatic read_delay(input logic ch, input int lane);
        read_reg(delay_addr(ch, lane), DATA_W'(dly_m[ch][lane]));
    endtask

    task automatic bus_idle();
        @(posedge clk);
        req_valid <= 1'b0;
        req_write <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // waits for a strobe, bounded
    task automatic wait_high(input int which, input int limit);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            @(negedge clk);
            seen = (which == 0) ? resp_valid : sample_valid;
        end
        if (!seen) begin
            $display("timeout: %s did not rise within %0d cycles",
                     (which == 0) ? "resp_valid" : "sample_valid", limit);
            stop_failed();
        end
    endtask

    initial begin
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        idle_cycles(4);
        read_reg(sfr_addr(REG_PAIR0), '0);  // slots cleared
        read_reg(sfr_addr(REG_FRAME_RATE), '0);
        bus_idle();
        wait_high(0, 4);

        send_samples(24);  // all delays zero
        wait_high(1, 8);

        // back to back writes and read-backs
        write_delay(1'b0, 3, 2);
        write_delay(1'b1, 5, 1);
        read_delay(1'b0, 3);
        read_delay(1'b1, 5);
        write_delay(1'b0, 7, 3);  // ignored
        read_delay(1'b0, 0);
        read_delay(1'b0, 3);
        read_delay(1'b1, 5);
        bus_idle();
        wait_high(0, 4);

        // lane 3 of A at delays 2, 1, 3
        for (int k = 0; k < 3; k++) begin
            if (k > 0) begin
                write_delay(1'b0, 3, (k == 1) ? 1 : 3);
                bus_idle();
                wait_high(0, 4);
            end
            idle_cycles(2);
            send_samples(16);
            wait_high(1, 8);
        end

        read_reg(sfr_addr(REG_PAIR0), slot_m[0]);
        read_reg(sfr_addr(REG_PAIR1), slot_m[1]);
        read_reg(sfr_addr(2'd3), '0);  // unmapped
        bus_idle();
        wait_high(0, 4);

        // a frame every second cycle, read once two windows have passed
        fork
            send_samples(80);
            begin
                idle_cycles(150);
                read_reg(sfr_addr(REG_FRAME_RATE), DATA_W'(GATE / 2));
                bus_idle();
                wait_high(0, 4);
            end
        join
        idle_cycles(2 * GATE + 8);  // one whole window without frames
        read_reg(sfr_addr(REG_FRAME_RATE), '0);
        bus_idle();
        wait_high(0, 4);
        idle_cycles(2);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
hdl/adc_pkg.sv
hdl/bus_pkg.sv
hdl/adc_capture_if.sv
hdl/reg_decode.sv
hdl/lane_capture.sv
hdl/capture_monitor.sv
hdl/adc_capture_top.sv
verification/adc_capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ADC capture testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module adc_capture_tb -f project.f -o adc_capture_sim

# tee keeps the log even when the simulator stops on an error
./obj_dir/adc_capture_sim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run_sim: testbench reported a failure"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: simulation ended without a result"
    exit 1
fi
echo "run_sim: done"
